//--- eeprom_pkg.sv
package eeprom_pkg;

    // word address width of a 2K x 8 part
    localparam int ADDR_W = 11;

    // device type code in the top nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // operations the bit engine knows
    typedef enum logic [2:0] {
        op_start,
        op_stop,
        op_write_byte,
        op_read_byte
    } bus_op_e;

    typedef struct packed {
        logic [3:0] dev;    // device code
        logic [2:0] block;  // upper address bits
        logic       rw;     // 1 = read
    } ctrl_fields_t;

    // control byte filled by field and shifted out as a plain byte
    typedef union packed {
        ctrl_fields_t f;
        logic [7:0]   raw;
    } ctrl_byte_u;

endpackage

//--- eeprom_cmd_regs.sv
`timescale 1ns/1ps

module eeprom_cmd_regs #(
    parameter int BLOCK_BITS = 3
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    input  logic                          busy,
    input  logic                          done,
    input  logic                          nack_seen,
    input  logic [7:0]                    rx_byte,
    input  logic                          rx_valid,
    output logic                          start_write,
    output logic                          start_read,
    output logic [eeprom_pkg::ADDR_W-1:0] cmd_addr,
    output logic [7:0]                    cmd_wdata,
    output logic [7:0]                    rdata,
    output logic                          ack,
    output logic                          nack_err
);

    localparam int AW = eeprom_pkg::ADDR_W;

    // keep only the word address and the block bits the part decodes
    localparam logic [AW-1:0] ADDR_MASK = AW'((32'd1 << (8 + BLOCK_BITS)) - 32'd1);

    logic hold;
    logic take_wr;
    logic take_rd;

    // the start pulse covers the cycle before busy rises
    assign hold    = busy || start_write || start_read;
    assign take_wr = wr && !hold;
    assign take_rd = rd && !wr && !hold;    // wr wins a tie

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start_write <= 1'b0;
            start_read  <= 1'b0;
            ack         <= 1'b0;
            nack_err    <= 1'b0;
            rdata       <= 8'h00;
        end
        else
        begin
            start_write <= take_wr;
            start_read  <= take_rd;
            ack         <= done;
            if (take_wr || take_rd)
                nack_err <= 1'b0;
            else if (done && nack_seen)
                nack_err <= 1'b1;
            if (rx_valid)
                rdata <= rx_byte;   // untouched on a nacked read
        end
    end

    always_ff @(posedge CLK)
    begin
        if (take_wr || take_rd)
        begin
            cmd_addr  <= addr & ADDR_MASK;
            cmd_wdata <= wdata;
        end
    end

endmodule

//--- eeprom_bit_engine.sv
`timescale 1ns/1ps

module eeprom_bit_engine (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                op_valid,
    input  eeprom_pkg::bus_op_e op,
    input  logic [7:0]          tx_byte,
    input  logic                last_read,
    input  logic                sda_in,
    output logic                op_done,
    output logic                ack_in,
    output logic [7:0]          rx_data,
    output logic                scl,
    output logic                sda_drive_low
);

    logic                active;
    logic [4:0]          step;          // cycle of the current op with the scl phase in bit 0
    logic [4:0]          nxt;
    logic [4:0]          last_step;
    eeprom_pkg::bus_op_e op_r;
    logic                last_read_r;
    logic [7:0]          shreg;         // tx bits leave at the top and rx bits enter at the bottom
    logic                is_byte;
    logic                advance;
    logic                rise;
    logic                fall;
    logic                data_bit;

    assign is_byte   = (op_r == eeprom_pkg::op_write_byte) || (op_r == eeprom_pkg::op_read_byte);
    assign last_step = is_byte ? 5'd17 : 5'd3;
    assign nxt       = step + 5'd1;
    assign advance   = active && (step != last_step);
    assign rise      = advance && is_byte && nxt[0];
    assign fall      = advance && is_byte && !nxt[0];
    assign data_bit  = (nxt[4:1] != 4'd8);     // bit 8 is the acknowledge slot
    assign rx_data   = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active        <= 1'b0;
            step          <= 5'd0;
            op_r          <= eeprom_pkg::op_start;
            last_read_r   <= 1'b0;
            op_done       <= 1'b0;
            ack_in        <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!active)
            begin
                if (op_valid)
                begin
                    active      <= 1'b1;
                    step        <= 5'd0;
                    op_r        <= op;
                    last_read_r <= last_read;
                    scl         <= 1'b0;
                    case (op)
                        eeprom_pkg::op_stop:       sda_drive_low <= 1'b1;
                        eeprom_pkg::op_write_byte: sda_drive_low <= ~tx_byte[7];
                        default:                   sda_drive_low <= 1'b0;
                    endcase
                end
            end
            else if (!advance)
            begin
                active  <= 1'b0;    // scl is already high here
                op_done <= 1'b1;
            end
            else
            begin
                step <= nxt;
                if (is_byte)
                begin
                    scl <= nxt[0];
                    if (fall)
                    begin
                        if (!data_bit)
                        begin
                            // master ack on a read and release on a write
                            if (op_r == eeprom_pkg::op_read_byte)
                                sda_drive_low <= ~last_read_r;
                            else
                                sda_drive_low <= 1'b0;
                        end
                        else if (op_r == eeprom_pkg::op_write_byte)
                        begin
                            sda_drive_low <= ~shreg[7];
                        end
                    end
                    else if (rise && !data_bit && op_r == eeprom_pkg::op_write_byte)
                    begin
                        ack_in <= ~sda_in;      // slave pulls low to ack
                    end
                end
                else
                begin
                    // scl held high while sda moves in the middle
                    scl <= 1'b1;
                    if (op_r == eeprom_pkg::op_start)
                        sda_drive_low <= (nxt >= 5'd2);
                    else
                        sda_drive_low <= (nxt <= 5'd1);
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && op_valid)
            shreg <= tx_byte;
        else if (rise && data_bit)
            shreg <= {shreg[6:0], sda_in};  // sample on rising scl
    end

endmodule

//--- eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer #(
    parameter int BLOCK_BITS = 3
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          start_write,
    input  logic                          start_read,
    input  logic [eeprom_pkg::ADDR_W-1:0] cmd_addr,
    input  logic [7:0]                    cmd_wdata,
    input  logic                          op_done,
    input  logic                          ack_in,
    input  logic [7:0]                    rx_data,
    output logic                          busy,
    output logic                          done,
    output logic                          nack_seen,
    output logic [7:0]                    rx_byte,
    output logic                          rx_valid,
    output logic                          op_valid,
    output eeprom_pkg::bus_op_e           op,
    output logic [7:0]                    tx_byte,
    output logic                          last_read
);

    localparam int S_IDLE    = 0;
    localparam int S_START   = 1;
    localparam int S_CTRL_W  = 2;
    localparam int S_ADDR    = 3;
    localparam int S_DATA_W  = 4;
    localparam int S_RESTART = 5;
    localparam int S_CTRL_R  = 6;
    localparam int S_DATA_R  = 7;
    localparam int S_STOP    = 8;
    localparam int S_DONE    = 9;
    localparam int NS        = 10;

    localparam logic [NS-1:0] ONE = NS'(1);

    logic [NS-1:0]          state;
    logic [NS-1:0]          state_n;
    logic                   rd_mode;
    logic                   byte_out;
    logic                   enter;
    eeprom_pkg::ctrl_byte_u ctrl;
    eeprom_pkg::bus_op_e    op_n;
    logic [7:0]             tx_n;

    assign busy     = ~state[S_IDLE];
    assign done     = state[S_DONE];
    assign byte_out = state[S_CTRL_W] | state[S_ADDR] | state[S_DATA_W] | state[S_CTRL_R];
    assign enter    = (state_n != state) && !state_n[S_IDLE] && !state_n[S_DONE];

    always_comb
    begin
        state_n = state;
        case (1'b1)
            state[S_IDLE]:    if (start_write || start_read) state_n = ONE << S_START;
            state[S_START]:   if (op_done) state_n = ONE << S_CTRL_W;
            state[S_CTRL_W]:  if (op_done) state_n = ack_in ? (ONE << S_ADDR) : (ONE << S_STOP);
            state[S_ADDR]:
            begin
                if (op_done && !ack_in)
                    state_n = ONE << S_STOP;
                else if (op_done)
                    state_n = rd_mode ? (ONE << S_RESTART) : (ONE << S_DATA_W);
            end
            state[S_DATA_W]:  if (op_done) state_n = ONE << S_STOP;
            state[S_RESTART]: if (op_done) state_n = ONE << S_CTRL_R;
            state[S_CTRL_R]:  if (op_done) state_n = ack_in ? (ONE << S_DATA_R) : (ONE << S_STOP);
            state[S_DATA_R]:  if (op_done) state_n = ONE << S_STOP;
            state[S_STOP]:    if (op_done) state_n = ONE << S_DONE;
            default:          state_n = ONE << S_IDLE;
        endcase
    end

    always_comb
    begin
        ctrl.f.dev   = eeprom_pkg::DEVICE_CODE;
        ctrl.f.block = 3'(cmd_addr[8 +: BLOCK_BITS]);
        ctrl.f.rw    = state_n[S_CTRL_R];   // read bit only after the restart

        op_n = eeprom_pkg::op_write_byte;
        if (state_n[S_START] || state_n[S_RESTART])
            op_n = eeprom_pkg::op_start;
        else if (state_n[S_STOP])
            op_n = eeprom_pkg::op_stop;
        else if (state_n[S_DATA_R])
            op_n = eeprom_pkg::op_read_byte;

        tx_n = 8'h00;
        if (state_n[S_CTRL_W] || state_n[S_CTRL_R])
            tx_n = ctrl.raw;
        else if (state_n[S_ADDR])
            tx_n = cmd_addr[7:0];
        else if (state_n[S_DATA_W])
            tx_n = cmd_wdata;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ONE << S_IDLE;
            rd_mode   <= 1'b0;
            nack_seen <= 1'b0;
            rx_valid  <= 1'b0;
            op_valid  <= 1'b0;
            op        <= eeprom_pkg::op_start;
            last_read <= 1'b0;
        end
        else
        begin
            state    <= state_n;
            op_valid <= 1'b0;
            rx_valid <= 1'b0;
            if (state[S_IDLE] && (start_write || start_read))
            begin
                rd_mode   <= start_read;
                nack_seen <= 1'b0;
            end
            if (op_done && byte_out && !ack_in)
                nack_seen <= 1'b1;
            if (op_done && state[S_DATA_R])
                rx_valid <= 1'b1;
            if (enter)
            begin
                op_valid  <= 1'b1;      // one op per state entry
                op        <= op_n;
                last_read <= state_n[S_DATA_R];
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (op_done && state[S_DATA_R])
            rx_byte <= rx_data;
        if (enter)
            tx_byte <= tx_n;
    end

endmodule

//--- eeprom_master_top.sv
`timescale 1ns/1ps

module eeprom_master_top #(
    parameter int BLOCK_BITS = 3
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    input  logic                          sda_in,
    output logic [7:0]                    rdata,
    output logic                          ack,
    output logic                          busy,
    output logic                          nack_err,
    output logic                          scl,
    output logic                          sda_drive_low
);

    logic                          start_write;
    logic                          start_read;
    logic [eeprom_pkg::ADDR_W-1:0] cmd_addr;
    logic [7:0]                    cmd_wdata;
    logic                          done;
    logic                          nack_seen;
    logic [7:0]                    rx_byte;
    logic                          rx_valid;
    logic                          op_valid;
    eeprom_pkg::bus_op_e           op;
    logic [7:0]                    tx_byte;
    logic                          last_read;
    logic                          op_done;
    logic                          ack_in;
    logic [7:0]                    rx_data;

    eeprom_cmd_regs #(
        .BLOCK_BITS (BLOCK_BITS)
    ) u_regs (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .busy        (busy),
        .done        (done),
        .nack_seen   (nack_seen),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .start_write (start_write),
        .start_read  (start_read),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .rdata       (rdata),
        .ack         (ack),
        .nack_err    (nack_err)
    );

    eeprom_sequencer #(
        .BLOCK_BITS (BLOCK_BITS)
    ) u_seq (
        .CLK         (CLK),
        .RESET       (RESET),
        .start_write (start_write),
        .start_read  (start_read),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .op_done     (op_done),
        .ack_in      (ack_in),
        .rx_data     (rx_data),
        .busy        (busy),
        .done        (done),
        .nack_seen   (nack_seen),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .op_valid    (op_valid),
        .op          (op),
        .tx_byte     (tx_byte),
        .last_read   (last_read)
    );

    eeprom_bit_engine u_bits (
        .CLK           (CLK),
        .RESET         (RESET),
        .op_valid      (op_valid),
        .op            (op),
        .tx_byte       (tx_byte),
        .last_read     (last_read),
        .sda_in        (sda_in),
        .op_done       (op_done),
        .ack_in        (ack_in),
        .rx_data       (rx_data),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK   = 1'b0;
        RESET = 1'b1;
        repeat (4) @(negedge CLK);  // four rising edges under reset
        RESET = 1'b0;
    end

    always #2 CLK = ~CLK;   // 4 ns period

endmodule

//--- eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low
);

    localparam logic [2:0] M_IDLE   = 3'd0;
    localparam logic [2:0] M_CTRL   = 3'd1;
    localparam logic [2:0] M_ADDR   = 3'd2;
    localparam logic [2:0] M_DATA_W = 3'd3;
    localparam logic [2:0] M_DATA_R = 3'd4;

    logic [7:0]  mem [0:2047];
    logic        scl_q;
    logic        sda_q;
    logic        low_hold;      // drive while scl is high
    logic        low_next;      // drive for the coming low phase
    logic [2:0]  state;
    logic [2:0]  after_ack;
    logic [3:0]  bitcnt;
    logic [7:0]  shreg;
    logic [10:0] ptr;

    // new bit shows as soon as scl falls and is held while scl is high
    assign sda_drive_low = scl ? low_hold : low_next;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
    end

    always @(posedge CLK)
    begin : decode
        logic [7:0] rx;
        int         nb;
        rx = {shreg[6:0], sda};
        nb = 6 - int'(bitcnt);
        if (RESET)
        begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            low_hold  <= 1'b0;
            low_next  <= 1'b0;
            state     <= M_IDLE;
            after_ack <= M_IDLE;
            bitcnt    <= 4'd0;
            shreg     <= 8'h00;
            ptr       <= 11'd0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && !scl)
                low_hold <= low_next;
            if (scl_q && scl && sda_q && !sda)
            begin
                state    <= M_CTRL;     // start or repeated start
                bitcnt   <= 4'd0;
                low_next <= 1'b0;
            end
            else if (scl_q && scl && !sda_q && sda)
            begin
                state    <= M_IDLE;     // stop
                low_next <= 1'b0;
            end
            else if (!scl_q && scl && state == M_DATA_R)
            begin
                if (bitcnt < 4'd8)
                begin
                    bitcnt   <= bitcnt + 4'd1;
                    low_next <= (nb >= 0) ? ~mem[ptr][nb] : 1'b0;
                end
                else
                begin
                    state    <= M_IDLE;     // master ack slot
                    low_next <= 1'b0;
                end
            end
            else if (!scl_q && scl && state != M_IDLE)
            begin
                if (bitcnt < 4'd8)
                begin
                    shreg  <= rx;
                    bitcnt <= bitcnt + 4'd1;
                    if (bitcnt == 4'd7)
                    begin
                        low_next <= 1'b1;
                        case (state)
                            M_CTRL:
                            begin
                                if (rx[7:4] == 4'b1010 && rx[3:1] < 3'd4)
                                begin
                                    after_ack <= rx[0] ? M_DATA_R : M_ADDR;
                                    if (!rx[0])
                                        ptr[10:8] <= rx[3:1];
                                end
                                else
                                begin
                                    low_next  <= 1'b0;  // not this device
                                    after_ack <= M_IDLE;
                                end
                            end
                            M_ADDR:
                            begin
                                ptr[7:0]  <= rx;
                                after_ack <= M_DATA_W;
                            end
                            default:
                            begin
                                mem[ptr]  <= rx;
                                after_ack <= M_IDLE;
                            end
                        endcase
                    end
                end
                else
                begin
                    bitcnt   <= 4'd0;
                    state    <= after_ack;
                    low_next <= (after_ack == M_DATA_R) ? ~mem[ptr][7] : 1'b0;
                end
            end
        end
    end

endmodule

//--- tb_eeprom_master.sv
`timescale 1ns/1ps

module tb_eeprom_master;

    localparam int NROWS        = 16;
    localparam int RESET_CYCLES = 4;
    localparam int LIMIT        = NROWS * 150 + RESET_CYCLES;
    localparam logic [10:0] POKE_ADDR = 11'h321;
    localparam logic [7:0]  POKE_DATA = 8'h77;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic        sda;
    logic        dut_low;
    logic        model_low;
    logic [7:0]  rdata;
    logic        ack;
    logic        busy;
    logic        nack_err;
    logic        scl;

    int          value_errors;
    int          other_errors;
    int          cycles;
    int          ack_count;
    logic [16:0] lfsr_state;
    logic [7:0]  shadow [0:2047];
    logic [7:0]  last_rdata;

    // row_src 0 keeps the last rdata
    // 1 takes row_exp and 2 the byte last written there
    logic        row_rd   [NROWS];
    logic [10:0] row_addr [NROWS];
    logic [7:0]  row_data [NROWS];
    logic        row_rnd  [NROWS];
    logic        row_nack [NROWS];
    int          row_src  [NROWS];
    logic [7:0]  row_exp  [NROWS];
    logic        row_poke [NROWS];

    tb_clock_gen u_clk (
        .CLK   (CLK),
        .RESET (RESET)
    );

    eeprom_master_top #(
        .BLOCK_BITS (3)
    ) u_dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wdata         (wdata),
        .sda_in        (sda),
        .rdata         (rdata),
        .ack           (ack),
        .busy          (busy),
        .nack_err      (nack_err),
        .scl           (scl),
        .sda_drive_low (dut_low)
    );

    eeprom_model u_mem (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda),
        .sda_drive_low (model_low)
    );

    assign sda = ~(dut_low | model_low);    // open-drain line with pull-up

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (!RESET && ack)
            ack_count <= ack_count + 1;
        if (cycles > LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
            lfsr_state = lfsr_state ^ 17'h12000;    // x^17 + x^14 + 1
        return b;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] v;
        v = 8'h00;
        for (int k = 0; k < 8; k++)
            v = {v[6:0], next_bit()};
        return v;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got %02h expected %02h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got %0h expected %0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic set_row(input int i, input logic is_rd, input logic [10:0] a,
                           input logic [7:0] d, input logic rnd, input logic nack,
                           input int src, input logic [7:0] exp, input logic poke);
        row_rd[i]   = is_rd;
        row_addr[i] = a;
        row_data[i] = d;
        row_rnd[i]  = rnd;
        row_nack[i] = nack;
        row_src[i]  = src;
        row_exp[i]  = exp;
        row_poke[i] = poke;
    endtask

    task automatic load_table();
        set_row(0,  0, 11'h000, 8'h00, 1, 0, 0, 8'h00, 0);
        set_row(1,  1, 11'h000, 8'h00, 0, 0, 2, 8'h00, 0);
        set_row(2,  0, 11'h3FF, 8'h00, 1, 0, 0, 8'h00, 0);  // top of block 3
        set_row(3,  1, 11'h3FF, 8'h00, 0, 0, 2, 8'h00, 0);
        set_row(4,  0, 11'h155, 8'hA5, 0, 0, 0, 8'h00, 0);
        set_row(5,  1, 11'h155, 8'h00, 0, 0, 1, 8'hA5, 0);
        set_row(6,  1, 11'h2AA, 8'h00, 0, 0, 1, 8'hFF, 0);  // never written
        set_row(7,  0, 11'h555, 8'h3C, 0, 1, 0, 8'h00, 0);  // block 5 has no device
        set_row(8,  1, 11'h155, 8'h00, 0, 0, 1, 8'hA5, 0);
        set_row(9,  1, 11'h400, 8'h00, 0, 1, 0, 8'h00, 0);
        set_row(10, 0, 11'h123, 8'h00, 1, 0, 0, 8'h00, 1);  // strobe again while busy
        set_row(11, 1, POKE_ADDR, 8'h00, 0, 0, 1, 8'hFF, 0);
        set_row(12, 1, 11'h123, 8'h00, 0, 0, 2, 8'h00, 0);
        set_row(13, 0, 11'h200, 8'h5A, 0, 0, 0, 8'h00, 0);
        set_row(14, 1, 11'h200, 8'h00, 0, 0, 1, 8'h5A, 0);
        set_row(15, 1, 11'h7FF, 8'h00, 0, 1, 0, 8'h00, 0);
    endtask

    task automatic run_row(input int i);
        logic [7:0] data;
        logic [7:0] exp;
        int         acks_before;
        data        = row_rnd[i] ? random_byte() : row_data[i];
        acks_before = ack_count;
        wr    = !row_rd[i];
        rd    = row_rd[i];
        addr  = row_addr[i];
        wdata = data;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        if (row_poke[i])
        begin
            while (!busy)
                @(negedge CLK);
            wr    = 1'b1;
            addr  = POKE_ADDR;
            wdata = POKE_DATA;
            @(negedge CLK);
            wr = 1'b0;
        end
        while (!ack)
            @(negedge CLK);
        if (!row_rd[i] && !row_nack[i])
            shadow[row_addr[i]] = data;
        case (row_src[i])
            1:       exp = row_exp[i];
            2:       exp = shadow[row_addr[i]];
            default: exp = last_rdata;
        endcase
        check_byte("rdata", rdata, exp);
        check_flag("nack_err", nack_err, row_nack[i]);
        last_rdata = exp;
        @(negedge CLK);
        @(negedge CLK);
        check_flag("busy", busy, 1'b0);
        check_flag("scl", scl, 1'b1);   // bus rests between transactions
        check_flag("sda_drive_low", dut_low, 1'b0);
        if (ack_count != acks_before + 1)
        begin
            $display("row %0d: expected one ack but saw %0d", i, ack_count - acks_before);
            other_errors++;
        end
    endtask

    initial
    begin
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = 11'd0;
        wdata        = 8'h00;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        ack_count    = 0;
        lfsr_state   = 17'd84320;
        last_rdata   = 8'h00;
        for (int j = 0; j < 2048; j++)
            shadow[j] = 8'hFF;
        load_table();

        @(negedge CLK);
        wait (!RESET);
        @(negedge CLK);
        check_flag("ack", ack, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("nack_err", nack_err, 1'b0);
        check_flag("scl", scl, 1'b1);
        check_flag("sda_drive_low", dut_low, 1'b0);
        check_byte("rdata", rdata, 8'h00);

        for (int i = 0; i < NROWS; i++)
            run_row(i);

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- verilog.f
eeprom_pkg.sv
eeprom_cmd_regs.sv
eeprom_bit_engine.sv
eeprom_sequencer.sv
eeprom_master_top.sv
tb_clock_gen.sv
eeprom_model.sv
tb_eeprom_master.sv

//--- run_sim.sh
#!/bin/sh
# build and run the EEPROM master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_eeprom_master \
    -f verilog.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
